//--- rtl/cache_pkg.sv
// Cache package with shared widths, vector types, bus structs and encodings
package cache_pkg;

   // Field widths of the CPU address and the data path
   localparam int WORD_W    = 16;
   localparam int ADDR_W    = 16;
   localparam int TAG_W     = 5;
   localparam int INDEX_W   = 8;
   localparam int WSEL_W    = 2;
   localparam int WADDR_W   = 15;
   localparam int COUNT_W   = 16;
   localparam int REG_SEL_W = 2;

   // Storage geometry
   localparam int LINES          = 256;
   localparam int WORDS_PER_LINE = 4;
   localparam int MEM_WORDS      = 32768;

   typedef logic [WORD_W-1:0]    word_t;
   typedef logic [ADDR_W-1:0]    addr_t;
   typedef logic [TAG_W-1:0]     tag_t;
   typedef logic [INDEX_W-1:0]   index_t;
   typedef logic [WSEL_W-1:0]    wsel_t;
   typedef logic [WADDR_W-1:0]   waddr_t;
   typedef logic [COUNT_W-1:0]   count_t;
   typedef logic [REG_SEL_W-1:0] reg_sel_t;

   // Register map
   localparam reg_sel_t REG_CTRL   = 2'd0;
   localparam reg_sel_t REG_HITS   = 2'd1;
   localparam reg_sel_t REG_MISSES = 2'd2;
   localparam reg_sel_t REG_WBACKS = 2'd3;

   // Array operations
   // WRITE sets dirty, FILL keeps it, INSTALL sets tag and valid and clears dirty
   typedef enum logic [1:0] {
      ARR_NONE,
      ARR_WRITE,
      ARR_FILL,
      ARR_INSTALL
   } arr_op_t;

   typedef enum logic [3:0] {
      IDLE,
      LOOKUP,
      WB_REQ,
      WB_WAIT,
      FILL_REQ,
      FILL_WAIT,
      BYP_REQ,
      BYP_WAIT,
      RESPOND,
      DROP
   } ctrl_state_t;

   typedef struct packed {
      logic  wr;
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   typedef struct packed {
      word_t rdata;
      logic  hit;
      logic  err;
   } cpu_rsp_t;

   typedef struct packed {
      logic   wr;
      waddr_t addr;
      word_t  wdata;
   } mem_req_t;

   typedef struct packed {
      arr_op_t op;
      index_t  index;
      wsel_t   wsel;
      tag_t    tag;
      word_t   wdata;
   } arr_cmd_t;

endpackage

//--- rtl/cache_array.sv
// Direct-mapped line storage with tag compare, word select and valid/dirty state
`timescale 1ns/1ps

module cache_array
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  arr_cmd_t cmd,
   output logic     line_hit,
   output logic     line_dirty,
   output tag_t     line_tag,
   output word_t    line_word
);

   word_t data_mem [WORDS_PER_LINE][LINES];
   tag_t  tag_mem [LINES];

   logic [LINES-1:0]          valid_q;
   logic [LINES-1:0]          dirty_q;
   logic                      match;
   logic                      wr_line;
   logic [WORDS_PER_LINE-1:0] wr_word;
   logic                      wr_tag;
   logic                      wr_valid;
   logic                      wr_dirty;
   logic                      dirty_in;

   // Valid line whose stored tag equals the command tag
   assign match = valid_q[cmd.index] && (tag_mem[cmd.index] == cmd.tag);

   // Operation decode into per-array write enables
   always_comb begin
      wr_line  = 1'b0;
      wr_tag   = 1'b0;
      wr_valid = 1'b0;
      wr_dirty = 1'b0;
      dirty_in = 1'b0;
      unique case (cmd.op)
         ARR_WRITE: begin
            // CPU store only lands on a matching line
            wr_line  = match;
            wr_dirty = match;
            dirty_in = 1'b1;
         end
         ARR_FILL: begin
            wr_line = 1'b1;
         end
         ARR_INSTALL: begin
            wr_tag   = 1'b1;
            wr_valid = 1'b1;
            wr_dirty = 1'b1;
            dirty_in = 1'b0;
         end
         default: begin
            wr_line = 1'b0;
         end
      endcase
   end

   // One-hot word enable from the offset word select
   assign wr_word = wr_line ? (WORDS_PER_LINE'(1) << cmd.wsel) : '0;

   always_ff @(posedge clk) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) begin
         if (wr_word[w]) begin
            data_mem[w][cmd.index] <= cmd.wdata;
         end
      end
      if (wr_tag) begin
         tag_mem[cmd.index] <= cmd.tag;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else begin
         if (wr_valid) begin
            valid_q[cmd.index] <= 1'b1;
         end
         if (wr_dirty) begin
            dirty_q[cmd.index] <= dirty_in;
         end
      end
   end

   assign line_hit   = match;
   assign line_dirty = valid_q[cmd.index] && dirty_q[cmd.index];
   assign line_tag   = tag_mem[cmd.index];
   assign line_word  = data_mem[cmd.wsel][cmd.index];

endmodule

//--- rtl/cache_ctrl.sv
// Cache controller FSM for CPU handshake, lookup, write-back, line fill and bypass
`timescale 1ns/1ps

module cache_ctrl
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cpu_req,
   input  cpu_req_t cpu_req_data,
   input  logic     cache_en,
   input  logic     line_hit,
   input  logic     line_dirty,
   input  tag_t     line_tag,
   input  word_t    line_word,
   input  logic     mem_ack,
   input  word_t    mem_rdata,
   output logic     cpu_ack,
   output cpu_rsp_t cpu_rsp,
   output arr_cmd_t arr_cmd,
   output logic     mem_req,
   output mem_req_t mem_req_data,
   output logic     hit_evt,
   output logic     miss_evt,
   output logic     wb_evt
);

   ctrl_state_t state;
   ctrl_state_t ret_state;
   cpu_req_t    req_q;
   cpu_rsp_t    rsp_q;
   mem_req_t    mreq_q;
   wsel_t       beat;
   logic        first;
   tag_t        req_tag;
   index_t      req_index;
   wsel_t       req_wsel;
   logic        odd;
   logic        lookup_miss;

   // Fields of the latched request
   assign req_tag   = req_q.addr[15:11];
   assign req_index = req_q.addr[10:3];
   assign req_wsel  = req_q.addr[2:1];
   assign odd       = req_q.addr[0];

   assign lookup_miss = (state == LOOKUP) && !odd && !line_hit;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= IDLE;
         ret_state <= IDLE;
         beat      <= '0;
         first     <= 1'b0;
      end else begin
         unique case (state)
            IDLE: begin
               if (cpu_req) begin
                  first <= 1'b1;
                  if (!cache_en && !cpu_req_data.addr[0]) begin
                     state <= BYP_REQ;
                  end else begin
                     state <= LOOKUP;
                  end
               end
            end
            LOOKUP: begin
               if (odd || line_hit) begin
                  state <= RESPOND;
               end else begin
                  first <= 1'b0;
                  beat  <= '0;
                  state <= line_dirty ? WB_REQ : FILL_REQ;
               end
            end
            WB_REQ:   state <= WB_WAIT;
            WB_WAIT: begin
               if (mem_ack) begin
                  beat      <= beat + 1'b1;
                  ret_state <= (beat == 2'd3) ? FILL_REQ : WB_REQ;
                  state     <= DROP;
               end
            end
            FILL_REQ: state <= FILL_WAIT;
            FILL_WAIT: begin
               if (mem_ack) begin
                  beat      <= beat + 1'b1;
                  ret_state <= (beat == 2'd3) ? LOOKUP : FILL_REQ;
                  state     <= DROP;
               end
            end
            BYP_REQ:  state <= BYP_WAIT;
            BYP_WAIT: begin
               if (mem_ack) begin
                  ret_state <= RESPOND;
                  state     <= DROP;
               end
            end
            // Memory ack must fall before the next word or the CPU answer
            DROP: begin
               if (!mem_ack) begin
                  state <= ret_state;
               end
            end
            RESPOND: begin
               if (!cpu_req) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Request, response and memory word registers
   always_ff @(posedge clk) begin
      if (state == IDLE && cpu_req) begin
         req_q <= cpu_req_data;
      end
      if (state == LOOKUP && (odd || line_hit)) begin
         rsp_q.err   <= odd;
         rsp_q.hit   <= !odd && first;
         rsp_q.rdata <= (odd || req_q.wr) ? '0 : line_word;
      end
      if (state == BYP_WAIT && mem_ack) begin
         rsp_q.err   <= 1'b0;
         rsp_q.hit   <= 1'b0;
         rsp_q.rdata <= req_q.wr ? '0 : mem_rdata;
      end
      if (state == WB_REQ) begin
         // Victim word goes back under its own tag
         mreq_q.wr    <= 1'b1;
         mreq_q.addr  <= {line_tag, req_index, beat};
         mreq_q.wdata <= line_word;
      end
      if (state == FILL_REQ) begin
         mreq_q.wr    <= 1'b0;
         mreq_q.addr  <= {req_tag, req_index, beat};
         mreq_q.wdata <= '0;
      end
      if (state == BYP_REQ) begin
         mreq_q.wr    <= req_q.wr;
         mreq_q.addr  <= req_q.addr[15:1];
         mreq_q.wdata <= req_q.wdata;
      end
   end

   // Array command follows the current state
   always_comb begin
      arr_cmd.op    = ARR_NONE;
      arr_cmd.index = req_index;
      arr_cmd.tag   = req_tag;
      arr_cmd.wsel  = req_wsel;
      arr_cmd.wdata = req_q.wdata;
      if (state == LOOKUP && !odd && line_hit && req_q.wr) begin
         arr_cmd.op = ARR_WRITE;
      end
      if (state == WB_REQ) begin
         arr_cmd.wsel = beat;
      end
      if (state == FILL_WAIT) begin
         arr_cmd.wsel  = beat;
         arr_cmd.wdata = mem_rdata;
         if (mem_ack) begin
            arr_cmd.op = ARR_FILL;
         end
      end
      // Tag goes in once the last fill word has been released
      if (state == DROP && !mem_ack && ret_state == LOOKUP) begin
         arr_cmd.op = ARR_INSTALL;
      end
   end

   assign cpu_ack      = (state == RESPOND);
   assign cpu_rsp      = rsp_q;
   assign mem_req      = (state == WB_WAIT) || (state == FILL_WAIT) || (state == BYP_WAIT);
   assign mem_req_data = mreq_q;

   assign hit_evt  = (state == LOOKUP) && first && !odd && line_hit;
   assign miss_evt = lookup_miss && first;
   assign wb_evt   = lookup_miss && line_dirty;

endmodule

//--- rtl/cache_regs.sv
// Configuration and statistics registers, enable bit and saturating event counters
`timescale 1ns/1ps

module cache_regs
   import cache_pkg::*;
(
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cfg_we,
   input  reg_sel_t cfg_sel,
   input  word_t    cfg_wdata,
   input  logic     hit_evt,
   input  logic     miss_evt,
   input  logic     wb_evt,
   output word_t    cfg_rdata,
   output logic     cache_en
);

   logic       en_q;
   count_t     cnt_q [3];
   logic [2:0] evt;

   // Counter order is hits, misses, write-backs
   assign evt = {wb_evt, miss_evt, hit_evt};

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         en_q <= 1'b1;
         for (int i = 0; i < 3; i++) begin
            cnt_q[i] <= '0;
         end
      end else if (cfg_we && cfg_sel == REG_CTRL) begin
         en_q <= cfg_wdata[0];
         for (int i = 0; i < 3; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < 3; i++) begin
            if (evt[i] && cnt_q[i] != '1) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   always_comb begin
      unique case (cfg_sel)
         REG_CTRL:   cfg_rdata = {{(WORD_W-1){1'b0}}, en_q};
         REG_HITS:   cfg_rdata = cnt_q[0];
         REG_MISSES: cfg_rdata = cnt_q[1];
         default:    cfg_rdata = cnt_q[2];
      endcase
   end

   assign cache_en = en_q;

endmodule

//--- rtl/mem_bank.sv
// Backing word memory with four-phase handshake and fixed response delay
`timescale 1ns/1ps

module mem_bank
   import cache_pkg::*;
#(
   parameter int mem_latency = 2
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     req,
   input  mem_req_t req_data,
   output logic     ack,
   output word_t    rdata
);

   localparam int cnt_w = (mem_latency > 1) ? $clog2(mem_latency) : 1;

   word_t            mem [MEM_WORDS];
   logic [cnt_w-1:0] cnt;
   logic             ack_q;
   word_t            rdata_q;
   logic             fire;

   // Known contents at time zero, word address XOR a fixed pattern
   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = word_t'(i) ^ 16'hA5A5;
      end
   end

   // Acknowledging edge, after mem_latency edges with req high
   assign fire = req && !ack_q && (cnt == cnt_w'(mem_latency - 1));

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt   <= '0;
         ack_q <= 1'b0;
      end else if (!req) begin
         cnt   <= '0;
         ack_q <= 1'b0;
      end else if (fire) begin
         cnt   <= '0;
         ack_q <= 1'b1;
      end else if (!ack_q) begin
         cnt <= cnt + 1'b1;
      end
   end

   // Array access happens once per handshake
   always_ff @(posedge clk) begin
      if (fire) begin
         if (req_data.wr) begin
            mem[req_data.addr] <= req_data.wdata;
         end else begin
            rdata_q <= mem[req_data.addr];
         end
      end
   end

   assign ack   = ack_q;
   assign rdata = rdata_q;

endmodule

//--- rtl/cache_top.sv
// Data cache top level joining controller, line array, registers and memory
`timescale 1ns/1ps

module cache_top
   import cache_pkg::*;
#(
   parameter int mem_latency = 2
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     cpu_req,
   input  cpu_req_t cpu_req_data,
   output logic     cpu_ack,
   output cpu_rsp_t cpu_rsp,
   input  logic     cfg_we,
   input  reg_sel_t cfg_sel,
   input  word_t    cfg_wdata,
   output word_t    cfg_rdata
);

   arr_cmd_t arr_cmd;
   logic     line_hit;
   logic     line_dirty;
   tag_t     line_tag;
   word_t    line_word;
   logic     mem_req;
   mem_req_t mem_req_data;
   logic     mem_ack;
   word_t    mem_rdata;
   logic     cache_en;
   logic     hit_evt;
   logic     miss_evt;
   logic     wb_evt;

   cache_ctrl u_ctrl (
      .clk          (clk),
      .arst_n       (arst_n),
      .cpu_req      (cpu_req),
      .cpu_req_data (cpu_req_data),
      .cache_en     (cache_en),
      .line_hit     (line_hit),
      .line_dirty   (line_dirty),
      .line_tag     (line_tag),
      .line_word    (line_word),
      .mem_ack      (mem_ack),
      .mem_rdata    (mem_rdata),
      .cpu_ack      (cpu_ack),
      .cpu_rsp      (cpu_rsp),
      .arr_cmd      (arr_cmd),
      .mem_req      (mem_req),
      .mem_req_data (mem_req_data),
      .hit_evt      (hit_evt),
      .miss_evt     (miss_evt),
      .wb_evt       (wb_evt)
   );

   cache_array u_array (
      .clk        (clk),
      .arst_n     (arst_n),
      .cmd        (arr_cmd),
      .line_hit   (line_hit),
      .line_dirty (line_dirty),
      .line_tag   (line_tag),
      .line_word  (line_word)
   );

   cache_regs u_regs (
      .clk       (clk),
      .arst_n    (arst_n),
      .cfg_we    (cfg_we),
      .cfg_sel   (cfg_sel),
      .cfg_wdata (cfg_wdata),
      .hit_evt   (hit_evt),
      .miss_evt  (miss_evt),
      .wb_evt    (wb_evt),
      .cfg_rdata (cfg_rdata),
      .cache_en  (cache_en)
   );

   mem_bank #(
      .mem_latency (mem_latency)
   ) u_mem (
      .clk      (clk),
      .arst_n   (arst_n),
      .req      (mem_req),
      .req_data (mem_req_data),
      .ack      (mem_ack),
      .rdata    (mem_rdata)
   );

endmodule

//--- test/tb_cache.sv
// Cache testbench with stimulus table, reference model, handshake checks and watchdog
`timescale 1ns/1ps

module tb_cache
   import cache_pkg::*;
();

   localparam logic [1:0] K_READ   = 2'd0;
   localparam logic [1:0] K_WRITE  = 2'd1;
   localparam logic [1:0] K_CFG_WR = 2'd2;
   localparam logic [1:0] K_CFG_RD = 2'd3;

   typedef struct packed {
      logic [2:0] test;
      logic [1:0] kind;
      addr_t      addr;
      word_t      data;
      word_t      exp_data;
      logic       exp_hit;
      logic       exp_err;
   } entry_t;

   logic     clk;
   logic     arst_n;
   logic     cpu_req;
   cpu_req_t cpu_req_data;
   logic     cpu_ack;
   cpu_rsp_t cpu_rsp;
   logic     cfg_we;
   reg_sel_t cfg_sel;
   word_t    cfg_wdata;
   word_t    cfg_rdata;

   // Reference model state
   word_t      sh_mem [MEM_WORDS];
   logic [255:0] m_valid;
   logic [255:0] m_dirty;
   tag_t       m_tag [LINES];
   logic       m_en;
   count_t     m_hits;
   count_t     m_misses;
   count_t     m_wbacks;

   entry_t     table_q [$];
   logic [2:0] cur_test;
   logic       table_ready = 1'b0;
   int         checks = 0;
   int         errors = 0;
   int         test_checks = 0;
   int         test_errors = 0;
   string      test_names [6] = '{"cold reads", "write then read back", "dirty eviction",
                                  "odd address", "bypass and random", "handshake order"};

   cache_top #(
      .mem_latency (2)
   ) dut (
      .clk          (clk),
      .arst_n       (arst_n),
      .cpu_req      (cpu_req),
      .cpu_req_data (cpu_req_data),
      .cpu_ack      (cpu_ack),
      .cpu_rsp      (cpu_rsp),
      .cfg_we       (cfg_we),
      .cfg_sel      (cfg_sel),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic check(input string what, input word_t got, input word_t exp);
      checks++;
      test_checks++;
      if (got !== exp) begin
         errors++;
         test_errors++;
         $display("FAIL t=%0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   function automatic count_t sat_inc(input count_t c);
      return (c == 16'hFFFF) ? c : c + 16'd1;
   endfunction

   // Model of one CPU access in the system view
   task automatic model_cpu(input logic wr, input addr_t addr, input word_t data,
                            output word_t rdata, output logic hit, output logic err);
      tag_t   t;
      index_t idx;
      waddr_t wa;
      t     = addr[15:11];
      idx   = addr[10:3];
      wa    = addr[15:1];
      rdata = '0;
      hit   = 1'b0;
      err   = addr[0];
      if (!err) begin
         if (m_en) begin
            hit = m_valid[idx] && (m_tag[idx] == t);
            if (hit) begin
               m_hits = sat_inc(m_hits);
            end else begin
               m_misses = sat_inc(m_misses);
               if (m_dirty[idx]) m_wbacks = sat_inc(m_wbacks);
               m_valid[idx] = 1'b1;
               m_dirty[idx] = 1'b0;
               m_tag[idx]   = t;
            end
            if (wr) m_dirty[idx] = 1'b1;
         end
         if (wr) sh_mem[wa] = data;
         else rdata = sh_mem[wa];
      end
   endtask

   function automatic word_t reg_value(input reg_sel_t sel);
      case (sel)
         REG_CTRL:   return {15'b0, m_en};
         REG_HITS:   return m_hits;
         REG_MISSES: return m_misses;
         default:    return m_wbacks;
      endcase
   endfunction

   task automatic add_cpu(input logic wr, input addr_t addr, input word_t data);
      entry_t e;
      e.test = cur_test;
      e.kind = wr ? K_WRITE : K_READ;
      e.addr = addr;
      e.data = data;
      model_cpu(wr, addr, data, e.exp_data, e.exp_hit, e.exp_err);
      table_q.push_back(e);
   endtask

   task automatic add_cfg(input logic wr, input reg_sel_t sel, input word_t data);
      entry_t e;
      e.test     = cur_test;
      e.kind     = wr ? K_CFG_WR : K_CFG_RD;
      e.addr     = addr_t'(sel);
      e.data     = data;
      e.exp_hit  = 1'b0;
      e.exp_err  = 1'b0;
      if (wr && sel == REG_CTRL) begin
         m_en     = data[0];
         m_hits   = '0;
         m_misses = '0;
         m_wbacks = '0;
      end
      e.exp_data = reg_value(sel);
      table_q.push_back(e);
   endtask

   task automatic add_counters();
      add_cfg(1'b0, REG_HITS, '0);
      add_cfg(1'b0, REG_MISSES, '0);
      add_cfg(1'b0, REG_WBACKS, '0);
   endtask

   task automatic build_table();
      addr_t a;
      cur_test = 3'd0;
      add_cpu(1'b0, 16'h0010, '0);
      add_cpu(1'b0, 16'h0014, '0);
      add_cpu(1'b0, 16'h0016, '0);
      add_cpu(1'b0, 16'h0800, '0);
      add_counters();
      cur_test = 3'd1;
      add_cpu(1'b1, 16'h0020, word_t'($urandom));
      add_cpu(1'b0, 16'h0020, '0);
      add_cpu(1'b1, 16'h0012, word_t'($urandom));
      add_cpu(1'b0, 16'h0012, '0);
      add_cpu(1'b1, 16'h1030, word_t'($urandom));
      add_cpu(1'b0, 16'h1030, '0);
      // Same index 8 under tags 0 and 1
      cur_test = 3'd2;
      add_cpu(1'b1, 16'h0040, word_t'($urandom));
      add_cpu(1'b1, 16'h0046, word_t'($urandom));
      add_cpu(1'b0, 16'h0840, '0);
      add_cpu(1'b0, 16'h0842, '0);
      add_cpu(1'b0, 16'h0040, '0);
      add_cpu(1'b0, 16'h0046, '0);
      add_counters();
      cur_test = 3'd3;
      add_cpu(1'b0, 16'h0013, '0);
      add_cpu(1'b1, 16'h0041, word_t'($urandom));
      add_counters();
      add_cpu(1'b0, 16'h0012, '0);
      add_cpu(1'b0, 16'h0040, '0);
      // Bypass uses index F0, which holds no line at that point
      cur_test = 3'd4;
      add_cfg(1'b1, REG_CTRL, 16'h0000);
      add_cfg(1'b0, REG_CTRL, '0);
      add_cpu(1'b0, 16'h7F80, '0);
      add_cpu(1'b1, 16'h7F82, word_t'($urandom));
      add_cpu(1'b0, 16'h7F82, '0);
      add_cpu(1'b0, 16'h8780, '0);
      add_counters();
      add_cfg(1'b1, REG_CTRL, 16'h0001);
      add_cfg(1'b0, REG_CTRL, '0);
      add_cpu(1'b0, 16'h7F82, '0);
      for (int i = 0; i < 24; i++) begin
         a = {3'b0, 2'($urandom), 5'b0, 3'($urandom), 2'($urandom), 1'b0};
         add_cpu(1'($urandom), a, word_t'($urandom));
      end
      // Counter registers are read-only
      add_cfg(1'b1, REG_HITS, 16'hFFFF);
      add_counters();
      cur_test = 3'd5;
      add_cpu(1'b0, 16'h0014, '0);
      add_cpu(1'b1, 16'h0016, word_t'($urandom));
      add_cpu(1'b0, 16'h0016, '0);
   endtask

   // Four-phase CPU access, entered and left 1 ns after a rising edge
   task automatic apply_cpu(input entry_t e);
      int edges;
      edges              = 0;
      cpu_req_data.wr    = (e.kind == K_WRITE);
      cpu_req_data.addr  = e.addr;
      cpu_req_data.wdata = e.data;
      cpu_req            = 1'b1;
      while (!cpu_ack) begin
         @(posedge clk);
         #1;
         edges++;
      end
      check("response data", cpu_rsp.rdata, e.exp_data);
      check("response hit", word_t'(cpu_rsp.hit), word_t'(e.exp_hit));
      check("response err", word_t'(cpu_rsp.err), word_t'(e.exp_err));
      if (e.exp_hit || e.exp_err) begin
         check("short access ack latency", word_t'(edges), 16'd2);
      end
      // Ack stays up while req is held
      @(posedge clk);
      #1;
      check("ack held with req high", word_t'(cpu_ack), 16'd1);
      cpu_req = 1'b0;
      @(negedge clk);
      check("ack before req sampled low", word_t'(cpu_ack), 16'd1);
      @(posedge clk);
      #1;
      check("ack after req sampled low", word_t'(cpu_ack), 16'd0);
   endtask

   task automatic apply_cfg(input entry_t e);
      cfg_sel = e.addr[1:0];
      if (e.kind == K_CFG_WR) begin
         cfg_we    = 1'b1;
         cfg_wdata = e.data;
         @(posedge clk);
         #1;
         cfg_we = 1'b0;
      end else begin
         @(negedge clk);
         check($sformatf("register %0d", e.addr[1:0]), cfg_rdata, e.exp_data);
         @(posedge clk);
         #1;
      end
   endtask

   initial begin
      entry_t e;
      cpu_req      = 1'b0;
      cpu_req_data = '0;
      cfg_we       = 1'b0;
      cfg_sel      = '0;
      cfg_wdata    = '0;
      arst_n       = 1'b0;
      void'($urandom(32'h354bf5c5));
      for (int i = 0; i < MEM_WORDS; i++) begin
         sh_mem[i] = word_t'(i) ^ 16'hA5A5;
      end
      for (int i = 0; i < LINES; i++) begin
         m_tag[i] = '0;
      end
      m_valid  = '0;
      m_dirty  = '0;
      m_en     = 1'b1;
      m_hits   = '0;
      m_misses = '0;
      m_wbacks = '0;
      build_table();
      table_ready = 1'b1;
      repeat (5) @(posedge clk);
      #1;
      arst_n = 1'b1;
      for (int i = 0; i < table_q.size(); i++) begin
         e = table_q[i];
         if (e.kind == K_READ || e.kind == K_WRITE) apply_cpu(e);
         else apply_cfg(e);
         if (i == table_q.size() - 1 || table_q[i + 1].test != e.test) begin
            $display("Test %0d %s: %0d checks, %0d mismatches", e.test,
                     test_names[e.test], test_checks, test_errors);
            test_checks = 0;
            test_errors = 0;
         end
      end
      $display("Totals: %0d entries, %0d checks, %0d mismatches", table_q.size(), checks,
               errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Bound of 200 clock cycles per table entry
   initial begin
      wait (table_ready);
      repeat (200 * table_q.size() + 10) @(posedge clk);
      $display("Timeout: a handshake hung and the run did not finish in time");
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- all.f
rtl/cache_pkg.sv
rtl/cache_array.sv
rtl/cache_ctrl.sv
rtl/cache_regs.sv
rtl/mem_bank.sv
rtl/cache_top.sv
test/tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f all.f --top-module tb_cache -o tb_cache

./obj_dir/tb_cache | tee sim.log

if grep -q "Simulation failed" sim.log; then
   echo "Cache simulation reported errors, see sim.log"
   exit 1
fi

echo "Cache simulation finished without errors"
exit 0
